// ==== flist.f ====
+incdir+src
src/disc_pkg.sv
src/disc_config_regs.sv
src/disc_level_detect.sv
src/disc_window_gate.sv
src/disc_timestamp.sv
src/sample_discriminator.sv
test/disc_clk_gen.sv
test/sample_discriminator_chk.sv
test/sample_discriminator_tb.sv

// ==== test/sample_discriminator_tb.sv ====
// sample discriminator testbench
// directed tests checked against a model of the hysteresis, window and run rules

`include "disc_defines.svh"

module sample_discriminator_tb import disc_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CH         = `DISC_CHANNELS;
  localparam int DEPTH      = `DISC_DEPTH;
  localparam int WAIT_LIMIT = 400;

  logic             adc_clk;
  logic             rst_n_i;
  logic             cfg_valid_i;
  cfg_op_e          cfg_op_i;
  chan_t            cfg_chan_i;
  logic [31:0]      cfg_data_i;
  batch_t  [CH-1:0] data_i;
  logic    [CH-1:0] data_valid_i;
  batch_t  [CH-1:0] data_o;
  logic    [CH-1:0] data_valid_o;
  tstamp_t [CH-1:0] tstamp_o;
  logic    [CH-1:0] tstamp_valid_o;

  batch_t      sent_q [CH][$];
  batch_t      got_data [CH][$];
  batch_t      exp_data [CH][$];
  tstamp_t     got_ts [CH][$];
  tstamp_t     exp_ts [CH][$];
  sample_t     m_low [CH];
  sample_t     m_high [CH];
  int          m_start [CH];
  int          m_stop [CH];
  logic        m_dis [CH];
  logic [15:0] lfsr_state = 16'd38703;
  int          errors = 0;
  int          checks = 0;

  disc_clk_gen u_clk (.adc_clk_o(adc_clk));

  sample_discriminator uut (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .cfg_valid_i    (cfg_valid_i),
    .cfg_op_i       (cfg_op_i),
    .cfg_chan_i     (cfg_chan_i),
    .cfg_data_i     (cfg_data_i),
    .data_i         (data_i),
    .data_valid_i   (data_valid_i),
    .data_o         (data_o),
    .data_valid_o   (data_valid_o),
    .tstamp_o       (tstamp_o),
    .tstamp_valid_o (tstamp_valid_o)
  );

  bind sample_discriminator sample_discriminator_chk u_chk (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (data_valid_i),
    .out_valid_i (data_valid_o),
    .ts_valid_i  (tstamp_valid_o)
  );

  always @(negedge adc_clk) begin
    for (int c = 0; c < CH; c++) begin
      if (data_valid_o[c]) begin
        got_data[c].push_back(data_o[c]);
      end
      if (tstamp_valid_o[c]) begin
        got_ts[c].push_back(tstamp_o[c]);
      end
    end
  end

  // x^16 + x^14 + x^13 + x^11 taps stepped once per bit
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      r = {r[14:0], fb};
    end
    return r;
  endfunction

  task automatic reset_dut();
    @(posedge adc_clk);
    #1;
    rst_n_i      = 1'b0;
    cfg_valid_i  = 1'b0;
    data_valid_i = '0;
    for (int c = 0; c < CH; c++) begin
      sent_q[c].delete();
      got_data[c].delete();
      got_ts[c].delete();
      m_low[c]   = '0;
      m_high[c]  = '0;
      m_start[c] = 0;
      m_stop[c]  = 0;
      m_dis[c]   = 1'b0;
    end
    repeat (3) @(posedge adc_clk);
    #1;
    rst_n_i = 1'b1;
  endtask

  task automatic write_cfg(input cfg_op_e op, input int ch, input logic [31:0] data);
    @(posedge adc_clk);
    #1;
    data_valid_i = '0;
    cfg_valid_i  = 1'b1;
    cfg_op_i     = op;
    cfg_chan_i   = chan_t'(ch);
    cfg_data_i   = data;
    @(posedge adc_clk);
    #1;
    cfg_valid_i = 1'b0;
    cfg_op_i    = CFG_NOP;
    if (op == CFG_THRESH) begin
      m_low[ch]  = sample_t'(data[15:0]);
      m_high[ch] = sample_t'(data[31:16]);
    end else if (op == CFG_DELAY) begin
      m_start[ch] = (data[7:0] > DEPTH) ? DEPTH : int'(data[7:0]);
      m_stop[ch]  = (data[15:8] > DEPTH) ? DEPTH : int'(data[15:8]);
    end else if (op == CFG_DISABLE) begin
      m_dis[ch] = data[0];
    end
  endtask

  // n random batches followed by DEPTH floor batches to drain the line
  task automatic send_stream(input int ch, input int n, input int gap_bits,
                             input bit poke_other);
    batch_t b;
    for (int i = 0; i < n + DEPTH; i++) begin
      if (poke_other && (i == 10 || i == 20)) begin
        write_cfg(CFG_THRESH, 1 - ch, 32'h0010_0005);
        write_cfg(CFG_DELAY, 1 - ch, 32'h0000_0404);
        write_cfg(CFG_DISABLE, 1 - ch, 32'h1);
      end
      for (int s = 0; s < `DISC_PAR_SAMPLES; s++) begin
        b[s] = (i < n) ? sample_t'(int'(rand_bits(10)) - 600) : sample_t'(16'h8000);
      end
      @(posedge adc_clk);
      #1;
      data_i[ch]       = b;
      data_valid_i[ch] = 1'b1;
      sent_q[ch].push_back(b);
      if (gap_bits > 0 && i < n) begin
        repeat (int'(rand_bits(gap_bits))) begin
          @(posedge adc_clk);
          #1;
          data_valid_i[ch] = 1'b0;
        end
      end
    end
    @(posedge adc_clk);
    #1;
    data_valid_i[ch] = 1'b0;
  endtask

  task automatic build_model(input int ch);
    logic    hi [$];
    logic    state;
    logic    above_high;
    logic    above_low;
    logic    keep;
    logic    prev;
    int      hold;
    int      kept;
    batch_t  b;
    tstamp_t ts;
    state = 1'b0;
    prev  = 1'b0;
    hold  = 0;
    kept  = 0;
    exp_data[ch].delete();
    exp_ts[ch].delete();
    for (int i = 0; i < sent_q[ch].size(); i++) begin
      b = sent_q[ch][i];
      above_high = 1'b0;
      above_low  = 1'b0;
      for (int s = 0; s < `DISC_PAR_SAMPLES; s++) begin
        above_high |= (b[s] > m_high[ch]);
        above_low  |= (b[s] > m_low[ch]);
      end
      if (above_high) state = 1'b1;
      if (!above_low) state = 1'b0;
      hi.push_back(state);
    end
    // only batches with DEPTH successors leave the line
    for (int i = 0; i < sent_q[ch].size() - DEPTH; i++) begin
      keep = m_dis[ch] || hi[i] || (hold != 0);
      for (int j = 1; j <= m_start[ch]; j++) begin
        keep |= hi[i+j];
      end
      if (hi[i]) hold = m_stop[ch];
      else if (hold != 0) hold--;
      if (keep) begin
        if (!prev) begin
          ts.batch_num = `DISC_TIME_W'(i);
          ts.kept_cnt  = `DISC_INDEX_W'(kept);
          exp_ts[ch].push_back(ts);
        end
        exp_data[ch].push_back(sent_q[ch][i]);
        kept++;
      end
      prev = keep;
    end
  endtask

  task automatic check_channel(input int ch);
    int cycles;
    build_model(ch);
    cycles = 0;
    while ((got_data[ch].size() < exp_data[ch].size() ||
            got_ts[ch].size() < exp_ts[ch].size()) && cycles < WAIT_LIMIT) begin
      @(posedge adc_clk);
      cycles++;
    end
    // the last batch leaves the line two cycles after its input valid
    repeat (3) @(posedge adc_clk);
    if (got_data[ch].size() < exp_data[ch].size() || got_ts[ch].size() < exp_ts[ch].size()) begin
      $display("timeout: channel %0d gave %0d of %0d batches and %0d of %0d timestamps",
               ch, got_data[ch].size(), exp_data[ch].size(),
               got_ts[ch].size(), exp_ts[ch].size());
      $display("TEST FAIL");
      $finish;
    end else begin
      checks += 2;
      assert (got_data[ch].size() == exp_data[ch].size()) else begin
        errors++;
        $display("FAIL %0t: ch%0d kept %0d batches, model %0d", $time, ch,
                 got_data[ch].size(), exp_data[ch].size());
      end
      assert (got_ts[ch].size() == exp_ts[ch].size()) else begin
        errors++;
        $display("FAIL %0t: ch%0d gave %0d timestamps, model %0d", $time, ch,
                 got_ts[ch].size(), exp_ts[ch].size());
      end
      for (int i = 0; i < exp_data[ch].size() && i < got_data[ch].size(); i++) begin
        checks++;
        assert (got_data[ch][i] == exp_data[ch][i]) else begin
          errors++;
          $display("FAIL %0t: ch%0d batch %0d is %h, model %h", $time, ch, i,
                   got_data[ch][i], exp_data[ch][i]);
        end
      end
      for (int i = 0; i < exp_ts[ch].size() && i < got_ts[ch].size(); i++) begin
        checks++;
        assert (got_ts[ch][i] == exp_ts[ch][i]) else begin
          errors++;
          $display("FAIL %0t: ch%0d timestamp %0d is %h, model %h", $time, ch, i,
                   got_ts[ch][i], exp_ts[ch][i]);
        end
      end
    end
  endtask

  initial begin
    #200us;
    $display("simulation time limit reached");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    rst_n_i      = 1'b0;
    cfg_valid_i  = 1'b0;
    cfg_op_i     = CFG_NOP;
    cfg_chan_i   = '0;
    cfg_data_i   = '0;
    data_i       = '0;
    data_valid_i = '0;

    // idle after reset
    reset_dut();
    repeat (50) @(posedge adc_clk);
    check_channel(0);
    check_channel(1);

    // disabled channel keeps every batch as one run
    reset_dut();
    write_cfg(CFG_DISABLE, 0, 32'h1);
    send_stream(0, 12, 0, 1'b0);
    check_channel(0);

    // zero delays at full rate
    reset_dut();
    write_cfg(CFG_THRESH, 0, {16'd300, 16'd100});
    send_stream(0, 40, 0, 1'b0);
    check_channel(0);
    // high of -50 below low of 150 lets set and clear meet in one batch
    reset_dut();
    write_cfg(CFG_THRESH, 0, {16'hffce, 16'd150});
    send_stream(0, 40, 0, 1'b0);
    check_channel(0);

    // look-ahead and hold-off with decimated valids where a stop of 12 saturates
    reset_dut();
    write_cfg(CFG_THRESH, 0, {16'd380, 16'd200});
    write_cfg(CFG_DELAY, 0, 32'h0000_0203);
    send_stream(0, 48, 2, 1'b0);
    check_channel(0);
    write_cfg(CFG_THRESH, 1, {16'd380, 16'd200});
    write_cfg(CFG_DELAY, 1, 32'h0000_0c08);
    send_stream(1, 48, 1, 1'b0);
    check_channel(1);

    // several short runs for timestamps
    reset_dut();
    write_cfg(CFG_THRESH, 1, {16'd400, 16'd250});
    write_cfg(CFG_DELAY, 1, 32'h0000_0101);
    send_stream(1, 60, 0, 1'b0);
    check_channel(1);

    // channel 1 rewritten while channel 0 runs
    reset_dut();
    write_cfg(CFG_THRESH, 0, {16'd300, 16'd100});
    write_cfg(CFG_DELAY, 0, 32'h0000_0102);
    send_stream(0, 30, 1, 1'b1);
    check_channel(0);
    check_channel(1);

    // protocol assertion failures count as errors too
    errors += uut.u_chk.fail_cnt;
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== test/sample_discriminator_chk.sv ====
// sample discriminator protocol checks
// output strobes against reset, timestamp pairing and input valids

`include "disc_defines.svh"

module sample_discriminator_chk (
  input logic                        adc_clk,
  input logic                        rst_n_i,
  input logic [`DISC_CHANNELS-1:0]   in_valid_i,
  input logic [`DISC_CHANNELS-1:0]   out_valid_i,
  input logic [`DISC_CHANNELS-1:0]   ts_valid_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;

  // strobes are cleared on the first reset edge
  assert property (@(posedge adc_clk)
    !rst_n_i |=> (out_valid_i == '0) && (ts_valid_i == '0))
    else begin
      fail_cnt++;
      $error("output strobe while reset is asserted");
    end

  assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (ts_valid_i & ~out_valid_i) == '0)
    else begin
      fail_cnt++;
      $error("timestamp strobe without a kept batch");
    end

  // two cycles after the input valid as the gate adds one to the detector's one
  assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (out_valid_i & ~$past(in_valid_i, 2)) == '0)
    else begin
      fail_cnt++;
      $error("kept batch without an input batch pushing it out");
    end

endmodule

// ==== test/disc_clk_gen.sv ====
// testbench clock source
// free-running adc_clk with a 4 ns period

module disc_clk_gen (
  output logic adc_clk_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial adc_clk_o = 1'b0;

  always #2 adc_clk_o = ~adc_clk_o;

endmodule

// ==== src/sample_discriminator.sv ====
// sample discriminator top level
// shared config registers, then per channel level detection, window gating
// and run timestamps

`include "disc_defines.svh"

module sample_discriminator import disc_pkg::*; (
  input  logic                           adc_clk,
  input  logic                           rst_n_i,
  input  logic                           cfg_valid_i,
  input  cfg_op_e                        cfg_op_i,
  input  chan_t                          cfg_chan_i,
  input  logic [31:0]                    cfg_data_i,
  input  batch_t  [`DISC_CHANNELS-1:0]   data_i,
  input  logic    [`DISC_CHANNELS-1:0]   data_valid_i,
  output batch_t  [`DISC_CHANNELS-1:0]   data_o,
  output logic    [`DISC_CHANNELS-1:0]   data_valid_o,
  output tstamp_t [`DISC_CHANNELS-1:0]   tstamp_o,
  output logic    [`DISC_CHANNELS-1:0]   tstamp_valid_o
);

  sample_t [`DISC_CHANNELS-1:0] thresh_low;
  sample_t [`DISC_CHANNELS-1:0] thresh_high;
  delay_t  [`DISC_CHANNELS-1:0] start_delay;
  delay_t  [`DISC_CHANNELS-1:0] stop_delay;
  logic    [`DISC_CHANNELS-1:0] chan_disable;

  disc_config_regs u_cfg (
    .adc_clk       (adc_clk),
    .rst_n_i       (rst_n_i),
    .cfg_valid_i   (cfg_valid_i),
    .cfg_op_i      (cfg_op_i),
    .cfg_chan_i    (cfg_chan_i),
    .cfg_data_i    (cfg_data_i),
    .thresh_low_o  (thresh_low),
    .thresh_high_o (thresh_high),
    .start_delay_o (start_delay),
    .stop_delay_o  (stop_delay),
    .disable_o     (chan_disable)
  );

  for (genvar ch = 0; ch < `DISC_CHANNELS; ch++) begin : g_chan
    batch_t lvl_data;
    logic   lvl_valid;
    logic   lvl_high;
    logic   advance;
    logic   run_start;

    disc_level_detect u_level (
      .adc_clk       (adc_clk),
      .rst_n_i       (rst_n_i),
      .data_i        (data_i[ch]),
      .valid_i       (data_valid_i[ch]),
      .thresh_low_i  (thresh_low[ch]),
      .thresh_high_i (thresh_high[ch]),
      .data_o        (lvl_data),
      .valid_o       (lvl_valid),
      .high_o        (lvl_high)
    );

    disc_window_gate u_gate (
      .adc_clk       (adc_clk),
      .rst_n_i       (rst_n_i),
      .data_i        (lvl_data),
      .valid_i       (lvl_valid),
      .high_i        (lvl_high),
      .start_delay_i (start_delay[ch]),
      .stop_delay_i  (stop_delay[ch]),
      .disable_i     (chan_disable[ch]),
      .data_o        (data_o[ch]),
      .valid_o       (data_valid_o[ch]),
      .advance_o     (advance),
      .run_start_o   (run_start)
    );

    // kept-count increments come from the registered output strobe
    disc_timestamp u_tstamp (
      .adc_clk        (adc_clk),
      .rst_n_i        (rst_n_i),
      .advance_i      (advance),
      .keep_i         (data_valid_o[ch]),
      .run_start_i    (run_start),
      .tstamp_o       (tstamp_o[ch]),
      .tstamp_valid_o (tstamp_valid_o[ch])
    );
  end

endmodule

// ==== src/disc_timestamp.sv ====
// run timestamp generator
// counts batches leaving the delay line and kept batches, and emits
// {batch number, kept count} at the first kept batch of each run

`include "disc_defines.svh"

module disc_timestamp import disc_pkg::*; (
  input  logic    adc_clk,
  input  logic    rst_n_i,
  input  logic    advance_i,
  input  logic    keep_i,
  input  logic    run_start_i,
  output tstamp_t tstamp_o,
  output logic    tstamp_valid_o
);

  logic [`DISC_TIME_W-1:0]  batch_cnt;
  logic [`DISC_INDEX_W-1:0] kept_cnt;

  // keep_i is the registered output strobe, so kept_cnt trails by a cycle.
  // a run start never directly follows a kept batch, so the count is
  // already settled when it is sampled
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      batch_cnt      <= '0;
      kept_cnt       <= '0;
      tstamp_valid_o <= 1'b0;
    end else begin
      tstamp_valid_o <= run_start_i;
      if (advance_i) begin
        batch_cnt <= batch_cnt + 1'b1;
      end
      if (keep_i) begin
        kept_cnt <= kept_cnt + 1'b1;
      end
    end
  end

  // same edge as the gate's data output
  always_ff @(posedge adc_clk) begin
    if (run_start_i) begin
      tstamp_o.batch_num <= batch_cnt;
      tstamp_o.kept_cnt  <= kept_cnt;
    end
  end

endmodule

// ==== src/disc_window_gate.sv ====
// window gate for one channel
// delays batches DISC_DEPTH valid batches so that later high flags can
// pull earlier batches in, and holds off after a high batch

`include "disc_defines.svh"

module disc_window_gate import disc_pkg::*; (
  input  logic   adc_clk,
  input  logic   rst_n_i,
  input  batch_t data_i,
  input  logic   valid_i,
  input  logic   high_i,
  input  delay_t start_delay_i,
  input  delay_t stop_delay_i,
  input  logic   disable_i,
  output batch_t data_o,
  output logic   valid_o,
  output logic   advance_o,
  output logic   run_start_o
);

  localparam int DEPTH = `DISC_DEPTH;

  batch_t             line_data [DEPTH];
  logic [DEPTH-1:0]   line_high;
  logic [DEPTH-1:0]   line_vld;
  logic [DEPTH:0]     flags;
  delay_t             holdoff;
  logic               lookahead;
  logic               keep;
  logic               prev_kept;

  // flags[0] is the incoming batch, flags[DEPTH] the one leaving
  assign flags = {line_high, high_i};

  always_comb begin
    lookahead = 1'b0;
    for (int j = 1; j <= DEPTH; j++) begin
      if (j <= int'(start_delay_i) && flags[DEPTH-j]) begin
        lookahead = 1'b1;
      end
    end
  end

  // oldest batch leaves once the line is full and a new one arrives
  assign advance_o   = valid_i & line_vld[DEPTH-1];
  assign keep        = flags[DEPTH] | lookahead | (holdoff != '0) | disable_i;
  assign run_start_o = advance_o & keep & ~prev_kept;

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      line_high <= '0;
      line_vld  <= '0;
      holdoff   <= '0;
      prev_kept <= 1'b0;
      valid_o   <= 1'b0;
    end else begin
      valid_o <= advance_o & keep;
      if (valid_i) begin
        line_high <= {line_high[DEPTH-2:0], high_i};
        line_vld  <= {line_vld[DEPTH-2:0], 1'b1};
      end
      if (advance_o) begin
        prev_kept <= keep;
        if (flags[DEPTH]) begin
          holdoff <= stop_delay_i;
        end else if (holdoff != '0) begin
          holdoff <= holdoff - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (valid_i) begin
      line_data[0] <= data_i;
      for (int k = 1; k < DEPTH; k++) begin
        line_data[k] <= line_data[k-1];
      end
    end
    if (advance_o && keep) begin
      data_o <= line_data[DEPTH-1];
    end
  end

endmodule

// ==== src/disc_level_detect.sv ====
// hysteresis level detector
// flags each valid batch high or low against a channel's two thresholds,
// one cycle of latency

`include "disc_defines.svh"

module disc_level_detect import disc_pkg::*; (
  input  logic    adc_clk,
  input  logic    rst_n_i,
  input  batch_t  data_i,
  input  logic    valid_i,
  input  sample_t thresh_low_i,
  input  sample_t thresh_high_i,
  output batch_t  data_o,
  output logic    valid_o,
  output logic    high_o
);

  logic any_above_high;
  logic any_above_low;
  logic state_high;
  logic next_high;

  always_comb begin
    any_above_high = 1'b0;
    any_above_low  = 1'b0;
    for (int i = 0; i < `DISC_PAR_SAMPLES; i++) begin
      if (data_i[i] > thresh_high_i) begin
        any_above_high = 1'b1;
      end
      if (data_i[i] > thresh_low_i) begin
        any_above_low = 1'b1;
      end
    end
  end

  // set first, then clear, so a batch below the low threshold always clears
  assign next_high = (state_high | any_above_high) & any_above_low;

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      state_high <= 1'b0;
      valid_o    <= 1'b0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        state_high <= next_high;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (valid_i) begin
      data_o <= data_i;
    end
  end

  assign high_o = state_high;

endmodule

// ==== src/disc_config_regs.sv ====
// discriminator configuration registers
// decodes strobed config writes into per-channel thresholds, delays and disable

`include "disc_defines.svh"

module disc_config_regs import disc_pkg::*; (
  input  logic                           adc_clk,
  input  logic                           rst_n_i,
  input  logic                           cfg_valid_i,
  input  cfg_op_e                        cfg_op_i,
  input  chan_t                          cfg_chan_i,
  input  logic [31:0]                    cfg_data_i,
  output sample_t [`DISC_CHANNELS-1:0]   thresh_low_o,
  output sample_t [`DISC_CHANNELS-1:0]   thresh_high_o,
  output delay_t  [`DISC_CHANNELS-1:0]   start_delay_o,
  output delay_t  [`DISC_CHANNELS-1:0]   stop_delay_o,
  output logic    [`DISC_CHANNELS-1:0]   disable_o
);

  // saturate at the line depth
  function automatic delay_t clamp_delay(input logic [7:0] req);
    delay_t result;
    if (req > 8'(`DISC_DEPTH)) begin
      result = delay_t'(`DISC_DEPTH);
    end else begin
      result = delay_t'(req);
    end
    return result;
  endfunction

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      thresh_low_o  <= '0;
      thresh_high_o <= '0;
      start_delay_o <= '0;
      stop_delay_o  <= '0;
      disable_o     <= '0;
    end else if (cfg_valid_i) begin
      case (cfg_op_i)
        CFG_THRESH: begin
          thresh_low_o[cfg_chan_i]  <= sample_t'(cfg_data_i[`DISC_SAMPLE_W-1:0]);
          thresh_high_o[cfg_chan_i] <= sample_t'(cfg_data_i[2*`DISC_SAMPLE_W-1:`DISC_SAMPLE_W]);
        end
        CFG_DELAY: begin
          start_delay_o[cfg_chan_i] <= clamp_delay(cfg_data_i[7:0]);
          stop_delay_o[cfg_chan_i]  <= clamp_delay(cfg_data_i[15:8]);
        end
        CFG_DISABLE: begin
          disable_o[cfg_chan_i] <= cfg_data_i[0];
        end
        // nop leaves everything as is
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== src/disc_pkg.sv ====
// sample discriminator types
// config opcodes, sample and batch layout, delay and timestamp words

`include "disc_defines.svh"

package disc_pkg;

  typedef enum logic [1:0] {
    CFG_NOP     = 2'd0,
    CFG_THRESH  = 2'd1,
    CFG_DELAY   = 2'd2,
    CFG_DISABLE = 2'd3
  } cfg_op_e;

  typedef logic signed [`DISC_SAMPLE_W-1:0] sample_t;

  // sample 0 sits in the low bits
  typedef sample_t [`DISC_PAR_SAMPLES-1:0] batch_t;

  typedef logic [$clog2(`DISC_DEPTH+1)-1:0] delay_t;
  typedef logic [$clog2(`DISC_CHANNELS)-1:0] chan_t;

  typedef struct packed {
    logic [`DISC_TIME_W-1:0]  batch_num;
    logic [`DISC_INDEX_W-1:0] kept_cnt;
  } tstamp_t;

endpackage

// ==== src/disc_defines.svh ====
// sample discriminator parameters
// channel count, batch geometry, delay-line depth and timestamp field widths

`ifndef DISC_DEFINES_SVH
`define DISC_DEFINES_SVH

`define DISC_CHANNELS 2
`define DISC_PAR_SAMPLES 4
`define DISC_SAMPLE_W 16

// also the largest start and stop delay, in batches
`define DISC_DEPTH 8

// timestamp word is batch number above kept count
`define DISC_TIME_W 24
`define DISC_INDEX_W 8

`endif
